// File: common/vpu_pkg.sv
package vpu_pkg;

    // ------------------------------------------------------------------------
    // Datapath geometry
    // ------------------------------------------------------------------------
    localparam int VLANE_CNT            = 4;
    localparam int OPERAND_WIDTH        = 8;
    localparam int EXEC_UNIT_DATA_WIDTH = 32;
    localparam int SRC_OPERAND_CNT      = 2;   // Operand A and operand B
    localparam int RED_WIDTH            = OPERAND_WIDTH + 2;  // Room for a 4-lane sum

    localparam int AXI_ADDR_WIDTH = 5;
    localparam int AXI_DATA_WIDTH = 32;
    localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

    typedef logic [OPERAND_WIDTH-1:0]        lane_data_t;
    typedef logic [EXEC_UNIT_DATA_WIDTH-1:0] exec_data_t;
    typedef logic [RED_WIDTH-1:0]            red_data_t;
    typedef logic [7:0]                      op_cnt_t;

    typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;
    typedef logic [AXI_STRB_WIDTH-1:0] axi_strb_t;
    typedef logic [1:0]                axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // ------------------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------------------
    localparam axi_addr_t REG_OPA    = 5'h00;
    localparam axi_addr_t REG_OPB    = 5'h04;
    localparam axi_addr_t REG_CTRL   = 5'h08;   // Bits 2..0 op, write starts
    localparam axi_addr_t REG_STATUS = 5'h0C;   // Busy, done, count in 15..8
    localparam axi_addr_t REG_RESULT = 5'h10;

    // Codes below OP_RSUM are elementwise
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_RSUM = 3'd5,
        OP_RMAX = 3'd6,
        OP_RMIN = 3'd7
    } vpu_op_e;

endpackage

// File: common/vpu_exec_if.sv
interface vpu_exec_if import vpu_pkg::*; ();

    logic                       start;          // One-cycle pulse
    vpu_op_e                    op;
    exec_data_t                 opa;
    exec_data_t                 opb;
    logic [SRC_OPERAND_CNT-1:0] operand_valid;  // Bit 0 for A, bit 1 for B
    exec_data_t                 result;         // Valid with done only
    logic                       done;

    modport issue (
        output start, op, opa, opb, operand_valid
    );

    modport exec (
        input  start, op, opa, opb, operand_valid,
        output result, done
    );

    modport monitor (
        input start, result, done
    );

endinterface

// File: hw/vpu_exec/vpu_lane.sv
module vpu_lane import vpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start_i,
    input  vpu_op_e    op_i,
    input  lane_data_t opa_i,
    input  lane_data_t opb_i,
    output lane_data_t dout_o,
    output logic       done_o
);

    lane_data_t alu_res;

    // ------------------------------------------------------------------------
    // 8-bit ALU, no carry leaves the lane
    // ------------------------------------------------------------------------
    always_comb begin
        case (op_i)
            OP_ADD: begin
                alu_res = opa_i + opb_i;   // Wraps at 8 bits
            end
            OP_SUB: begin
                alu_res = opa_i - opb_i;
            end
            OP_AND: begin
                alu_res = opa_i & opb_i;
            end
            OP_OR: begin
                alu_res = opa_i | opb_i;
            end
            OP_XOR: begin
                alu_res = opa_i ^ opb_i;
            end
            default: begin
                alu_res = '0;              // Reductions are not handled here
            end
        endcase
    end

    // Result register, loaded on start only
    always_ff @(posedge clk) begin
        if (start_i)
            dout_o <= alu_res;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            done_o <= 1'b0;
        else
            done_o <= start_i;             // One cycle latency
    end

endmodule

// File: hw/vpu_exec/vpu_reduction_unit.sv
module vpu_reduction_unit import vpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start_i,
    input  vpu_op_e    op_i,
    input  exec_data_t operand_i,
    output exec_data_t dout_o,
    output logic       done_o
);

    red_data_t lane_val [VLANE_CNT];
    red_data_t pair_q   [VLANE_CNT/2];
    vpu_op_e   op_s1_q;
    red_data_t fold_q;
    logic      s1_valid_q;
    logic      s2_valid_q;

    // Unsigned fold of two values, wide enough that the sum never wraps
    function automatic red_data_t fold(input vpu_op_e op, input red_data_t a,
                                       input red_data_t b);
        case (op)
            OP_RSUM: fold = a + b;
            OP_RMAX: fold = (a > b) ? a : b;
            OP_RMIN: fold = (a < b) ? a : b;
            default: fold = '0;
        endcase
    endfunction

    always_comb begin
        for (int k = 0; k < VLANE_CNT; k++)
            lane_val[k] = red_data_t'(operand_i[k*OPERAND_WIDTH +: OPERAND_WIDTH]);
    end

    // ------------------------------------------------------------------------
    // Stage 1 folds lane pairs, stage 2 folds the pairs
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (start_i) begin
            for (int p = 0; p < VLANE_CNT/2; p++)
                pair_q[p] <= fold(op_i, lane_val[2*p], lane_val[2*p+1]);
            op_s1_q <= op_i;       // Op travels with the data
        end
        if (s1_valid_q)
            fold_q <= fold(op_s1_q, pair_q[0], pair_q[1]);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= start_i;
            s2_valid_q <= s1_valid_q;
        end
    end

    assign dout_o = exec_data_t'(fold_q);   // Zero-extended
    assign done_o = s2_valid_q;

endmodule

// File: hw/vpu_exec/vpu_exec_unit.sv
module vpu_exec_unit import vpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    vpu_exec_if.exec  exec_io
);

    exec_data_t           opa_m;
    exec_data_t           opb_m;
    exec_data_t           lane_dout;
    exec_data_t           red_dout;
    logic [VLANE_CNT-1:0] lane_done;
    logic                 red_done;
    logic                 is_elem;

    // Unwritten operands count as zero
    assign opa_m = exec_io.operand_valid[0] ? exec_io.opa : '0;
    assign opb_m = exec_io.operand_valid[1] ? exec_io.opb : '0;

    // ------------------------------------------------------------------------
    // Elementwise lanes
    // ------------------------------------------------------------------------
    for (genvar k = 0; k < VLANE_CNT; k++) begin : g_lane
        vpu_lane u_lane (
            .clk     (clk),
            .rst_n   (rst_n),
            .start_i (exec_io.start),
            .op_i    (exec_io.op),
            .opa_i   (opa_m[k*OPERAND_WIDTH +: OPERAND_WIDTH]),
            .opb_i   (opb_m[k*OPERAND_WIDTH +: OPERAND_WIDTH]),
            .dout_o  (lane_dout[k*OPERAND_WIDTH +: OPERAND_WIDTH]),
            .done_o  (lane_done[k])
        );
    end

    vpu_reduction_unit u_reduction (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (exec_io.start),
        .op_i      (exec_io.op),
        .operand_i (opa_m),          // Reductions fold operand A only
        .dout_o    (red_dout),
        .done_o    (red_done)
    );

    assign is_elem = (exec_io.op < OP_RSUM);

    // All lanes run in lockstep, lane 0 speaks for them
    always_comb begin
        if (is_elem) begin
            exec_io.result = lane_dout;
            exec_io.done   = lane_done[0];
        end else begin
            exec_io.result = red_dout;
            exec_io.done   = red_done;
        end
    end

endmodule

// File: hw/vpu_axil_regs.sv
module vpu_axil_regs import vpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    input  axi_addr_t  s_awaddr_i,
    input  logic       s_awvalid_i,
    output logic       s_awready_o,
    input  axi_data_t  s_wdata_i,
    input  axi_strb_t  s_wstrb_i,
    input  logic       s_wvalid_i,
    output logic       s_wready_o,
    output axi_resp_t  s_bresp_o,
    output logic       s_bvalid_o,
    input  logic       s_bready_i,
    input  axi_addr_t  s_araddr_i,
    input  logic       s_arvalid_i,
    output logic       s_arready_o,
    output axi_data_t  s_rdata_o,
    output axi_resp_t  s_rresp_o,
    output logic       s_rvalid_o,
    input  logic       s_rready_i,

    vpu_exec_if.issue  exec_o,
    input  logic       busy_i,
    input  logic       done_flag_i,
    input  op_cnt_t    op_cnt_i,
    input  exec_data_t result_i
);

    exec_data_t                 opa_q;
    exec_data_t                 opb_q;
    vpu_op_e                    op_q;
    logic [SRC_OPERAND_CNT-1:0] opnd_valid_q;
    logic                       start_q;

    logic      wr_accept;
    logic      wr_hs;
    logic      wr_ok;
    logic      start_req;
    logic      rd_hs;
    axi_data_t rdata_d;
    axi_resp_t rresp_d;

    // ------------------------------------------------------------------------
    // Write channel
    // ------------------------------------------------------------------------
    assign wr_accept = s_awvalid_i && s_wvalid_i && !s_awready_o && !s_bvalid_o;
    assign wr_hs     = s_awready_o && s_awvalid_i && s_wready_o && s_wvalid_i;
    assign start_req = wr_hs && (s_awaddr_i == REG_CTRL) && !busy_i && !start_q;

    always_comb begin
        case (s_awaddr_i)
            REG_OPA, REG_OPB, REG_CTRL: wr_ok = 1'b1;
            default:                    wr_ok = 1'b0;   // RESULT and STATUS too
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_awready_o <= 1'b0;
            s_wready_o  <= 1'b0;
            s_bvalid_o  <= 1'b0;
            s_bresp_o   <= RESP_OKAY;
        end else begin
            s_awready_o <= wr_accept;
            s_wready_o  <= wr_accept;
            if (wr_hs) begin
                s_bvalid_o <= 1'b1;
                s_bresp_o  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
            end else if (s_bready_i) begin
                s_bvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            opa_q        <= '0;
            opb_q        <= '0;
            op_q         <= OP_ADD;
            opnd_valid_q <= '0;
            start_q      <= 1'b0;
        end else begin
            start_q <= start_req;      // Pulse in the cycle after the handshake
            if (start_q)
                opnd_valid_q <= '0;
            if (start_req)
                op_q <= vpu_op_e'(s_wdata_i[2:0]);
            if (wr_hs && s_awaddr_i == REG_OPA) begin
                for (int b = 0; b < AXI_STRB_WIDTH; b++)
                    if (s_wstrb_i[b])
                        opa_q[b*8 +: 8] <= s_wdata_i[b*8 +: 8];
                opnd_valid_q[0] <= 1'b1;
            end
            if (wr_hs && s_awaddr_i == REG_OPB) begin
                for (int b = 0; b < AXI_STRB_WIDTH; b++)
                    if (s_wstrb_i[b])
                        opb_q[b*8 +: 8] <= s_wdata_i[b*8 +: 8];
                opnd_valid_q[1] <= 1'b1;
            end
        end
    end

    assign exec_o.start         = start_q;
    assign exec_o.op            = op_q;
    assign exec_o.opa           = opa_q;
    assign exec_o.opb           = opb_q;
    assign exec_o.operand_valid = opnd_valid_q;

    // ------------------------------------------------------------------------
    // Read channel
    // ------------------------------------------------------------------------
    assign rd_hs = s_arready_o && s_arvalid_i;

    always_comb begin
        rdata_d = '0;
        rresp_d = RESP_OKAY;
        case (s_araddr_i)
            REG_OPA:    rdata_d = opa_q;
            REG_OPB:    rdata_d = opb_q;
            REG_CTRL:   rdata_d = axi_data_t'(op_q);
            REG_STATUS: begin
                rdata_d[0]    = busy_i;
                rdata_d[1]    = done_flag_i;
                rdata_d[15:8] = op_cnt_i;
            end
            REG_RESULT: rdata_d = result_i;
            default:    rresp_d = RESP_SLVERR;   // Data stays zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_arready_o <= 1'b0;
            s_rvalid_o  <= 1'b0;
            s_rdata_o   <= '0;
            s_rresp_o   <= RESP_OKAY;
        end else if (rd_hs) begin
            s_arready_o <= 1'b0;
            s_rvalid_o  <= 1'b1;
            s_rdata_o   <= rdata_d;
            s_rresp_o   <= rresp_d;
        end else if (s_rvalid_o) begin
            if (s_rready_i) begin
                s_rvalid_o  <= 1'b0;
                s_arready_o <= 1'b1;
            end
        end else begin
            s_arready_o <= 1'b1;
        end
    end

endmodule

// File: hw/vpu_result_store.sv
module vpu_result_store import vpu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    vpu_exec_if.monitor mon_i,
    output logic        busy_o,
    output logic        done_flag_o,
    output op_cnt_t     op_cnt_o,
    output exec_data_t  result_o
);

    // ------------------------------------------------------------------------
    // Status flags
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_o      <= 1'b0;
            done_flag_o <= 1'b0;
        end else begin
            if (mon_i.done)
                busy_o <= 1'b0;
            else if (mon_i.start)
                busy_o <= 1'b1;

            // Sticky until the next operation starts
            if (mon_i.start)
                done_flag_o <= 1'b0;
            else if (mon_i.done)
                done_flag_o <= 1'b1;
        end
    end

    // Result is only valid in the done cycle, hold it for read-back
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_cnt_o <= '0;
            result_o <= '0;
        end else if (mon_i.done) begin
            op_cnt_o <= op_cnt_o + 1'b1;   // Wraps at 256
            result_o <= mon_i.result;
        end
    end

endmodule

// File: hw/vpu_top.sv
module vpu_top import vpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  axi_addr_t s_awaddr_i,
    input  logic      s_awvalid_i,
    output logic      s_awready_o,
    input  axi_data_t s_wdata_i,
    input  axi_strb_t s_wstrb_i,
    input  logic      s_wvalid_i,
    output logic      s_wready_o,
    output axi_resp_t s_bresp_o,
    output logic      s_bvalid_o,
    input  logic      s_bready_i,
    input  axi_addr_t s_araddr_i,
    input  logic      s_arvalid_i,
    output logic      s_arready_o,
    output axi_data_t s_rdata_o,
    output axi_resp_t s_rresp_o,
    output logic      s_rvalid_o,
    input  logic      s_rready_i
);

    logic       busy;
    logic       done_flag;
    op_cnt_t    op_cnt;
    exec_data_t result;

    vpu_exec_if exec_if ();

    // ------------------------------------------------------------------------
    // Register front end
    // ------------------------------------------------------------------------
    vpu_axil_regs u_axil_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wstrb_i   (s_wstrb_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .exec_o      (exec_if.issue),
        .busy_i      (busy),
        .done_flag_i (done_flag),
        .op_cnt_i    (op_cnt),
        .result_i    (result)
    );

    vpu_exec_unit u_exec_unit (
        .clk     (clk),
        .rst_n   (rst_n),
        .exec_io (exec_if.exec)
    );

    // Status and captured result, read back through STATUS and RESULT
    vpu_result_store u_result_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .mon_i       (exec_if.monitor),
        .busy_o      (busy),
        .done_flag_o (done_flag),
        .op_cnt_o    (op_cnt),
        .result_o    (result)
    );

endmodule

// File: sim/vpu_tb.sv
module vpu_tb import vpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_PAT        = 20;
    localparam int PAT_COLS       = 6;
    localparam int TIMEOUT_CYCLES = NUM_PAT * 200;

    logic      clk;
    logic      rst_n;

    axi_addr_t s_awaddr;
    logic      s_awvalid;
    logic      s_awready;
    axi_data_t s_wdata;
    axi_strb_t s_wstrb;
    logic      s_wvalid;
    logic      s_wready;
    axi_resp_t s_bresp;
    logic      s_bvalid;
    logic      s_bready;
    axi_addr_t s_araddr;
    logic      s_arvalid;
    logic      s_arready;
    axi_data_t s_rdata;
    axi_resp_t s_rresp;
    logic      s_rvalid;
    logic      s_rready;

    logic [31:0] pat [NUM_PAT*PAT_COLS];
    int          seed;
    int          cycle_cnt;
    op_cnt_t     exp_cnt;

    vpu_top vpu_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .s_awaddr_i  (s_awaddr),
        .s_awvalid_i (s_awvalid),
        .s_awready_o (s_awready),
        .s_wdata_i   (s_wdata),
        .s_wstrb_i   (s_wstrb),
        .s_wvalid_i  (s_wvalid),
        .s_wready_o  (s_wready),
        .s_bresp_o   (s_bresp),
        .s_bvalid_o  (s_bvalid),
        .s_bready_i  (s_bready),
        .s_araddr_i  (s_araddr),
        .s_arvalid_i (s_arvalid),
        .s_arready_o (s_arready),
        .s_rdata_o   (s_rdata),
        .s_rresp_o   (s_rresp),
        .s_rvalid_o  (s_rvalid),
        .s_rready_i  (s_rready)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
            $display("Test FAILED");
            $fatal(1, "Run aborted on timeout");
        end
    end

    // ------------------------------------------------------------------------
    // Bus helpers
    // ------------------------------------------------------------------------
    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "Run aborted at first error");
        end
    endtask

    // Ready is low about one cycle in four
    function automatic logic draw_ready(input logic backpressure);
        draw_ready = !backpressure || (($random(seed) & 3) != 0);
    endfunction

    task automatic write_reg(input axi_addr_t addr, input axi_data_t data,
                             input logic backpressure, output axi_resp_t resp);
        s_awaddr  <= addr;
        s_awvalid <= 1'b1;
        s_wdata   <= data;
        s_wstrb   <= '1;
        s_wvalid  <= 1'b1;
        do begin
            @(posedge clk);
        end while (!s_awready);      // AW and W are accepted together
        check("s_wready", s_wready, 1'b1);
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        s_bready  <= draw_ready(backpressure);
        forever begin
            @(posedge clk);
            if (s_bvalid && s_bready)
                break;
            s_bready <= draw_ready(backpressure);
        end
        resp = s_bresp;
        s_bready <= 1'b0;
    endtask

    task automatic read_reg(input axi_addr_t addr, output axi_data_t data,
                            output axi_resp_t resp);
        s_araddr  <= addr;
        s_arvalid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!s_arready);
        s_arvalid <= 1'b0;
        s_rready  <= draw_ready(1'b1);
        forever begin
            @(posedge clk);
            if (s_rvalid && s_rready)
                break;
            s_rready <= draw_ready(1'b1);
        end
        data = s_rdata;
        resp = s_rresp;
        s_rready <= 1'b0;
    endtask

    task automatic poll_done(output axi_data_t status);
        axi_resp_t resp;

        do begin
            read_reg(REG_STATUS, status, resp);
            check("rresp STATUS", resp, RESP_OKAY);
        end while (!status[1]);
    endtask

    // ------------------------------------------------------------------------
    // One pattern line
    // ------------------------------------------------------------------------
    task automatic run_pattern(input int p);
        logic [31:0] mask;
        logic [31:0] opa;
        logic [31:0] opb;
        logic [31:0] op;
        logic [31:0] exp_res;
        logic [31:0] extra;
        logic [3:0]  kind;
        axi_addr_t   xaddr;
        axi_resp_t   xresp;
        axi_resp_t   resp;
        axi_data_t   data;

        mask    = pat[p*PAT_COLS];
        opa     = pat[p*PAT_COLS+1];
        opb     = pat[p*PAT_COLS+2];
        op      = pat[p*PAT_COLS+3];
        exp_res = pat[p*PAT_COLS+4];
        extra   = pat[p*PAT_COLS+5];
        kind    = extra[15:12];
        xaddr   = axi_addr_t'(extra[11:4]);
        xresp   = extra[1:0];

        if (mask[0]) begin
            write_reg(REG_OPA, opa, 1'b1, resp);
            check("bresp OPA", resp, RESP_OKAY);
            read_reg(REG_OPA, data, resp);
            check("rdata OPA", data, opa);
        end
        if (mask[1]) begin
            write_reg(REG_OPB, opb, 1'b1, resp);
            check("bresp OPB", resp, RESP_OKAY);
            read_reg(REG_OPB, data, resp);
            check("rdata OPB", data, opb);
        end

        // Busy case keeps bready high so the second CTRL write hits the busy window
        write_reg(REG_CTRL, op, kind != 4'd3, resp);
        check("bresp CTRL", resp, RESP_OKAY);
        exp_cnt = exp_cnt + 1'b1;
        if (kind == 4'd3) begin
            write_reg(REG_CTRL, OP_ADD, 1'b0, resp);
            check("bresp CTRL busy", resp, RESP_OKAY);
        end

        poll_done(data);
        check("status busy", data[0], 1'b0);
        check("status count", data[15:8], exp_cnt);
        read_reg(REG_RESULT, data, resp);
        check("rresp RESULT", resp, RESP_OKAY);
        check("result", data, exp_res);
        read_reg(REG_CTRL, data, resp);
        check("ctrl op", data, op);

        case (kind)
            4'd1: begin
                write_reg(xaddr, ~exp_res, 1'b1, resp);
                check("bresp extra", resp, xresp);
                read_reg(REG_RESULT, data, resp);
                check("result after write", data, exp_res);
            end
            4'd2: begin
                read_reg(xaddr, data, resp);
                check("rresp extra", resp, xresp);
                if (xresp == RESP_SLVERR)
                    check("rdata unmapped", data, '0);
            end
            default: ;
        endcase
    endtask

    initial begin
        axi_data_t data;
        axi_resp_t resp;

        seed      = 38;
        cycle_cnt = 0;
        exp_cnt   = '0;
        clk       = 1'b0;
        rst_n     = 1'b0;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;

        $readmemh("sim/vpu_patterns.txt", pat);
        if ($isunknown(pat[0])) begin
            $display("Could not read the pattern file sim/vpu_patterns.txt");
            $display("Test FAILED");
            $fatal(1, "No stimulus");
        end

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        read_reg(REG_STATUS, data, resp);
        check("status after reset", data, '0);
        read_reg(REG_RESULT, data, resp);
        check("result after reset", data, '0);

        for (int p = 0; p < NUM_PAT; p++)
            run_pattern(p);

        $display("Test OK");
        $finish;
    end

endmodule

// File: sim/vpu_patterns.txt
// Columns are mask, operand A, operand B, op, expected result and extra access
// Extra bits 15..12 give the kind (1 write, 2 read, 3 CTRL write while busy)
// Extra bits 11..4 give the offset and bits 3..0 the expected response
3 80FF7F01 80017F01 0 0000FE02 0000
3 00102030 01010101 1 FF0F1F2F 0000
3 F0F0AA55 FF0FFF0F 2 F000AA05 0000
3 12345678 80808080 3 92B4D6F8 0000
3 DEADBEEF FFFFFFFF 4 21524110 0000
1 FFFFFFFF 00000000 5 000003FC 0000
1 10FE0380 00000000 6 000000FE 0000
1 10FE0380 00000000 7 00000003 0000
3 01020304 10101010 0 11121314 0000
// B left unwritten after the last start
1 05050505 00000000 0 05050505 0000
2 00000000 01000001 1 FF0000FF 0000
0 00000000 00000000 6 00000000 0000
1 7F80FF01 00000000 5 000001FF 3000
3 A5A5A5A5 5A5A5A5A 4 FFFFFFFF 1102
3 11223344 44332211 3 55333355 2142
3 FF00FF00 01010101 0 00010001 10C2
1 00010203 00000000 7 00000000 11C2
1 80808080 00000000 5 00000200 2182
3 00000001 00000002 1 000000FF 2000
1 7F7F7F7F 00000000 6 0000007F 0000

// File: vpu_top.f
common/vpu_pkg.sv
common/vpu_exec_if.sv
hw/vpu_exec/vpu_lane.sv
hw/vpu_exec/vpu_reduction_unit.sv
hw/vpu_exec/vpu_exec_unit.sv
hw/vpu_axil_regs.sv
hw/vpu_result_store.sv
hw/vpu_top.sv
sim/vpu_tb.sv
